/* hdl/imul_consts.svh */
// width constants for the iterative multiplier
// the counter width must hold IMUL_STEPS_M1, so keep the two in step
// when IMUL_WIDTH changes
`ifndef IMUL_CONSTS_SVH
`define IMUL_CONSTS_SVH

// operand width in bits, two's complement
`define IMUL_WIDTH 32

// full product, twice the operand width
`define IMUL_PROD_WIDTH (2 * `IMUL_WIDTH)

// step counter width, enough for IMUL_WIDTH - 1
`define IMUL_CNT_WIDTH 5

// counter load value
// one shift-add step per operand bit, counted down to zero
`define IMUL_STEPS_M1 31

`endif

/* hdl/imul_ctrl.sv */
// FSM of the iterative multiplier
// one operation at a time, a new request waits until the response
// has been taken
`timescale 1ns/1ns

module imul_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  input  imul_ctrl_pkg::dpath_status_t status,
  output imul_ctrl_pkg::dpath_ctrl_t   ctrl
);

  import imul_ctrl_pkg::*;

  mul_state_e state;
  mul_state_e state_nxt;

  // handshake events on this edge
  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      // wait for a request
      st_idle: begin
        if (req_go) begin
          state_nxt = st_calc;
        end
      end
      // the step taken with last_step high is the final one
      st_calc: begin
        if (status.last_step) begin
          state_nxt = st_done;
        end
      end
      // hold the result under back-pressure
      st_done: begin
        if (resp_go) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // --------------------------------------------------
  // output decode
  // --------------------------------------------------

  // handshake follows the state alone
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // datapath commands
  always_comb begin
    // load only on the accepting edge
    ctrl.load = req_go;
    // step on every calc cycle, including the final one
    ctrl.step = (state == st_calc);
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // a new request is never taken while a result is waiting
  a_hs_excl: assert property (
    @(posedge clk) disable iff (reset)
      !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  // steps run only from a load up to the step the datapath flags as final
  a_step_in_calc: assert property (
    @(posedge clk) disable iff (reset)
      ctrl.step |-> $past(ctrl.load) || ($past(ctrl.step) && !$past(status.last_step))
  ) else $error("step outside a running operation");

  // state must be known from the first cycle after reset
  a_state_known: assert property (
    @(posedge clk) disable iff (reset)
      !$isunknown(state)
  ) else $error("state unknown");

endmodule

/* hdl/imul_ctrl_pkg.sv */
// control types shared by the FSM and the datapath
// no widths depend on the operand size here
package imul_ctrl_pkg;

  // --------------------------------------------------
  // FSM states
  // --------------------------------------------------

  // idle waits for a request, calc runs the steps,
  // done holds the result until it is taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } mul_state_e;

  // --------------------------------------------------
  // control to datapath
  // --------------------------------------------------

  typedef struct packed {
    // capture a new request, one cycle wide
    logic load;
    // one shift-add step
    logic step;
  } dpath_ctrl_t;

  // datapath to control
  typedef struct packed {
    // counter at zero, this step is the final one
    logic last_step;
  } dpath_status_t;

endpackage

/* hdl/imul_data_pkg.sv */
// data types of the multiplier
// widths come from imul_consts.svh
package imul_data_pkg;

  `include "imul_consts.svh"

  // --------------------------------------------------
  // scalar types
  // --------------------------------------------------

  // one operand, or the magnitude of one
  typedef logic [`IMUL_WIDTH-1:0] operand_t;

  // full width product, also used for the accumulator
  typedef logic [`IMUL_PROD_WIDTH-1:0] product_t;

  // step counter, counts down from IMUL_STEPS_M1
  typedef logic [`IMUL_CNT_WIDTH-1:0] count_t;

  // --------------------------------------------------
  // request message
  // --------------------------------------------------

  // both operands are signed two's complement
  typedef struct packed {
    operand_t a;
    operand_t b;
  } mul_req_t;

endpackage

/* hdl/imul_dpath.sv */
// datapath of the iterative multiplier
// only the counter is reset, the operand and accumulator registers are
// valid only from a load on
`timescale 1ns/1ns

`include "imul_consts.svh"

module imul_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  imul_data_pkg::mul_req_t      req_msg,
  input  imul_ctrl_pkg::dpath_ctrl_t   ctrl,
  output imul_ctrl_pkg::dpath_status_t status,
  output imul_data_pkg::product_t      resp_result
);

  import imul_data_pkg::*;

  // --------------------------------------------------
  // magnitude conversion
  // --------------------------------------------------

  // two's complement only for a negative input
  // the most negative value maps onto itself, which is its correct
  // unsigned magnitude
  function automatic operand_t magnitude(input operand_t v);
    operand_t neg;
    neg = ~v + operand_t'(1);
    return v[`IMUL_WIDTH-1] ? neg : v;
  endfunction

  operand_t mag_a;
  operand_t mag_b;
  logic     sign_a;
  logic     sign_b;

  assign sign_a = req_msg.a[`IMUL_WIDTH-1];
  assign sign_b = req_msg.b[`IMUL_WIDTH-1];
  assign mag_a  = magnitude(req_msg.a);
  assign mag_b  = magnitude(req_msg.b);

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  // a shifts left across the full product width
  product_t a_q;
  // b shifts right, its low bit picks the add
  operand_t b_q;
  // running unsigned product
  product_t acc_q;
  // steps still to run after this one
  count_t   cnt_q;
  // operand signs of the operation in flight
  logic     sign_a_q;
  logic     sign_b_q;

  // add term for this step, zero when b's low bit is clear
  product_t add_term;

  assign add_term = b_q[0] ? a_q : '0;

  // operand and accumulator registers
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      a_q      <= {{`IMUL_WIDTH{1'b0}}, mag_a};
      b_q      <= mag_b;
      acc_q    <= '0;
      sign_a_q <= sign_a;
      sign_b_q <= sign_b;
    end else if (ctrl.step) begin
      acc_q <= acc_q + add_term;
      a_q   <= a_q << 1;
      b_q   <= b_q >> 1;
    end
  end

  // step counter
  // wraps past zero on the last step, which the FSM ignores since it
  // leaves calc on that edge
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (ctrl.load) begin
      cnt_q <= count_t'(`IMUL_STEPS_M1);
    end else if (ctrl.step) begin
      cnt_q <= cnt_q - count_t'(1);
    end
  end

  assign status.last_step = (cnt_q == '0);

  // --------------------------------------------------
  // result sign
  // --------------------------------------------------

  // negative when exactly one operand was negative
  // the registers hold still in done, so the result is stable
  // for as long as resp_val stays high
  logic     neg_result;
  product_t acc_neg;

  assign neg_result  = sign_a_q ^ sign_b_q;
  assign acc_neg     = ~acc_q + product_t'(1);
  assign resp_result = neg_result ? acc_neg : acc_q;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the FSM must never load over a running operation
  a_load_step_excl: assert property (
    @(posedge clk) disable iff (reset)
      !(ctrl.load && ctrl.step)
  ) else $error("load and step asserted together");

endmodule

/* hdl/imul_iterative.sv */
// iterative signed 32x32 multiplier, 64-bit product
// 32 cycles from the accepting edge to resp_val, one operation in flight
`timescale 1ns/1ns

module imul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  // request port
  input  imul_data_pkg::mul_req_t  req_msg,
  input  logic                     req_val,
  output logic                     req_rdy,
  // response port
  output imul_data_pkg::product_t  resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import imul_ctrl_pkg::*;

  // commands and status between the two blocks
  dpath_ctrl_t   ctrl;
  dpath_status_t status;

  // FSM and handshake
  imul_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .status   (status),
    .ctrl     (ctrl)
  );

  // operand, counter and accumulator registers
  imul_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_msg     (req_msg),
    .ctrl        (ctrl),
    .status      (status),
    .resp_result (resp_result)
  );

endmodule

/* list.f */
+incdir+hdl
hdl/imul_data_pkg.sv
hdl/imul_ctrl_pkg.sv
hdl/imul_dpath.sv
hdl/imul_ctrl.sv
hdl/imul_iterative.sv
sim/imul_tb.sv

/* run.sh */
#!/bin/sh
# builds the multiplier testbench with Verilator and runs it
# logs land in the project root, the exit status tells pass or fail

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module imul_tb \
  -f list.f \
  -o imul_sim > "$build_log" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  cat "$build_log"
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/imul_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the testbench prints the pass line only when every check held
if grep -qx "Verification passed" "$sim_log"; then
  echo "run passed"
  exit 0
else
  echo "run failed, see $sim_log"
  exit 1
fi

/* sim/imul_tb.sv */
// self-checking testbench for the iterative multiplier
// a monitor checks every transfer against a reference product, the
// stimulus only drives requests and resp_rdy
`timescale 1ns/1ns

module imul_tb;

  import imul_data_pkg::*;

  // cycles a single wait may take before the run is aborted
  localparam int wait_limit  = 200;
  localparam int latency_exp = 32;

  logic     clk;
  logic     reset;
  mul_req_t req_msg;
  logic     req_val;
  logic     req_rdy;
  product_t resp_result;
  logic     resp_val;
  logic     resp_rdy;

  // scoreboard state
  product_t    exp_q[$];
  product_t    held_result;
  logic        in_resp;
  int          cyc;
  int          accept_cyc;
  int          accept_count;
  int          resp_count;
  int          latency_checks;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  int unsigned lcg_state;

  imul_iterative u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_msg     (req_msg),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // edge counter for the latency measurement
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // signed product, both operands sign-extended to 64 bits first
  function automatic product_t ref_product(input operand_t a, input operand_t b);
    longint sa;
    longint sb;
    sa = longint'(signed'(a));
    sb = longint'(signed'(b));
    return product_t'(sa * sb);
  endfunction

  // 32-bit LCG, low bits are weak so stall lengths use the high ones
  function automatic operand_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return operand_t'(lcg_state);
  endfunction

  task automatic check_equal(input product_t got, input product_t expected,
                             input string what);
    if (got !== expected) begin
      err_count++;
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, err_count - errs_before);
    end
  endtask

  // closing summary, the only place the run ends
  task automatic end_run();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    err_count++;
    $display("timed out at %0t ns after %0d cycles waiting for %s", $time, wait_limit, what);
    end_run();
  endtask

  // --------------------------------------------------
  // request and response tasks
  // --------------------------------------------------

  task automatic present_req(input operand_t a, input operand_t b);
    @(posedge clk);
    req_msg.a <= a;
    req_msg.b <= b;
    req_val   <= 1'b1;
  endtask

  // returns just after the accepting edge, with req_val dropped
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!(req_val && req_rdy)) begin
      n++;
      if (n > wait_limit) begin
        abort_on_timeout("a request to be accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  // returns at the falling edge of the first cycle with resp_val high
  task automatic wait_resp_valid();
    int n;
    n = 0;
    @(negedge clk);
    while (!resp_val) begin
      n++;
      if (n > wait_limit) begin
        abort_on_timeout("resp_val");
      end
      @(negedge clk);
    end
  endtask

  // returns just after the edge where the response transfers
  task automatic wait_resp_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!(resp_val && resp_rdy)) begin
      n++;
      if (n > wait_limit) begin
        abort_on_timeout("a response transfer");
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_op(input operand_t a, input operand_t b);
    present_req(a, b);
    wait_accept();
    wait_resp_done();
  endtask

  // --------------------------------------------------
  // monitor and compare
  // --------------------------------------------------

  // samples at the falling edge and predicts the coming rising edge
  initial begin : monitor
    product_t expected;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (req_val && req_rdy) begin
          // a result still queued here means it would be lost
          check_equal(product_t'(exp_q.size()), product_t'(0),
                      "request accepted with a result outstanding");
          exp_q.push_back(ref_product(req_msg.a, req_msg.b));
          accept_cyc = cyc + 1;
          accept_count++;
        end
        if (resp_val) begin
          check_equal(product_t'(req_rdy), product_t'(0), "req_rdy high with resp_val");
          if (!in_resp) begin
            check_equal(product_t'(cyc - accept_cyc), product_t'(latency_exp), "latency");
            latency_checks++;
            held_result = resp_result;
            in_resp     = 1'b1;
          end else begin
            check_equal(resp_result, held_result, "resp_result changed under stall");
          end
          if (resp_rdy) begin
            if (exp_q.size() == 0) begin
              err_count++;
              $display("response at %0t ns with no request outstanding", $time);
            end else begin
              expected = exp_q.pop_front();
              check_equal(resp_result, expected, "product");
            end
            resp_count++;
            in_resp = 1'b0;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin : stimulus
    int errs;
    int stall;
    int resp_before;
    int i;
    reset          = 1'b1;
    req_msg        = '0;
    req_val        = 1'b0;
    resp_rdy       = 1'b0;
    cyc            = 0;
    accept_cyc     = 0;
    accept_count   = 0;
    resp_count     = 0;
    latency_checks = 0;
    err_count      = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    in_resp        = 1'b0;
    held_result    = '0;
    lcg_state      = 98105;
    repeat (10) @(posedge clk);
    reset    <= 1'b0;
    resp_rdy <= 1'b1;

    // idle right after reset
    errs = err_count;
    @(negedge clk);
    check_equal(product_t'(req_rdy), product_t'(1), "req_rdy after reset");
    check_equal(product_t'(resp_val), product_t'(0), "resp_val after reset");
    report_test("reset_state", errs);

    // corner operands and the four sign combinations
    errs = err_count;
    run_op(32'h0000_0000, 32'h0001_2345);
    run_op(32'h0000_0001, 32'h0000_0001);
    run_op(32'hffff_ffff, 32'hffff_ffff);
    run_op(32'h0000_0001, 32'hffff_ffff);
    run_op(32'h7fff_ffff, 32'h7fff_ffff);
    run_op(32'h8000_0000, 32'h8000_0000);
    run_op(32'h7fff_ffff, 32'h8000_0000);
    run_op(32'h8000_0000, 32'hffff_ffff);
    // 7 and 3 with every sign pairing
    run_op(32'h0000_0007, 32'h0000_0003);
    run_op(32'h0000_0007, 32'hffff_fffd);
    run_op(32'hffff_fff9, 32'h0000_0003);
    run_op(32'hffff_fff9, 32'hffff_fffd);
    report_test("directed", errs);

    // next request is presented as soon as the previous one is taken
    errs = err_count;
    for (i = 0; i < 200; i++) begin
      present_req(lcg_next(), lcg_next());
      wait_accept();
    end
    wait_resp_done();
    check_equal(product_t'(resp_count), product_t'(accept_count), "random response count");
    report_test("random", errs);

    // every operation so far had its latency measured
    errs = err_count;
    for (i = 0; i < 4; i++) begin
      run_op(lcg_next(), lcg_next());
    end
    check_equal(product_t'(latency_checks), product_t'(accept_count), "latency checks");
    report_test("latency", errs);

    // resp_rdy low for 0 to 20 cycles, 0 means no stall at all
    errs = err_count;
    for (i = 0; i < 10; i++) begin
      stall = int'((lcg_next() >> 16) % 32'd21);
      if (stall > 0) begin
        @(posedge clk);
        resp_rdy <= 1'b0;
      end
      present_req(lcg_next(), lcg_next());
      wait_accept();
      if (stall > 0) begin
        wait_resp_valid();
        repeat (stall) @(posedge clk);
        resp_rdy <= 1'b1;
      end
      wait_resp_done();
    end
    report_test("back_pressure", errs);

    // second request waits behind a stalled result
    errs        = err_count;
    resp_before = resp_count;
    @(posedge clk);
    resp_rdy <= 1'b0;
    present_req(32'h1234_5678, 32'hfedc_ba98);
    wait_accept();
    present_req(32'h8000_0001, 32'h0000_7fff);
    wait_resp_valid();
    repeat (5) @(posedge clk);
    resp_rdy <= 1'b1;
    wait_accept();
    check_equal(product_t'(resp_count), product_t'(resp_before + 1), "first result first");
    wait_resp_done();
    check_equal(product_t'(resp_count), product_t'(resp_before + 2), "hold-off responses");
    report_test("hold_off", errs);

    check_equal(product_t'(exp_q.size()), product_t'(0), "results left outstanding");
    check_equal(product_t'(resp_count), product_t'(accept_count), "total response count");
    end_run();
  end

endmodule
